// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -j 0
TOP       := tb_mem_bus_unit
FILELIST  := filelist.f
OBJ_DIR   := obj_dir

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qxF '>>> PASS'

clean:
	rm -rf $(OBJ_DIR)

// File: filelist.f
logic/bus_pkg.sv
logic/line_req_if.sv
logic/axi_rd_if.sv
logic/line_read_engine.sv
logic/read_arbiter.sv
logic/line_write_engine.sv
logic/mem_bus_unit.sv
verif/axi_mem_model.sv
verif/tb_mem_bus_unit.sv

// File: logic/axi_rd_if.sv
`timescale 1ns/1ps
`default_nettype none

interface axi_rd_if
    import bus_pkg::*;
();

    // address channel
    logic  arvalid;
    addr_t araddr;
    logic  arready;

    // data channel, already filtered by ID
    logic  rvalid;
    word_t rdata;
    logic  rlast;
    logic  rready;

    modport master (
        output arvalid,
        output araddr,
        input  arready,
        input  rvalid,
        input  rdata,
        input  rlast,
        output rready
    );

    modport slave (
        input  arvalid,
        input  araddr,
        output arready,
        output rvalid,
        output rdata,
        output rlast,
        input  rready
    );

endinterface

`default_nettype wire

// File: logic/bus_pkg.sv
`default_nettype none

package bus_pkg;

    // bus and line geometry
    localparam int ADDR_W     = 32;
    localparam int WORD_W     = 32;
    localparam int LINE_WORDS = 4;
    localparam int LINE_W     = LINE_WORDS * WORD_W;
    localparam int ID_W       = 4;
    localparam int BEAT_W     = 2;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [WORD_W-1:0] word_t;
    typedef logic [LINE_W-1:0] line_t;
    typedef logic [ID_W-1:0]   axi_id_t;

    // read IDs, one per line reader
    localparam axi_id_t ICACHE_ID = 4'd0;
    localparam axi_id_t DCACHE_ID = 4'd1;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_ADDR,
        RD_DATA,
        RD_DONE
    } rd_state_e;

    typedef enum logic [2:0] {
        WR_IDLE,
        WR_ADDR,
        WR_DATA,
        WR_RESP,
        WR_DONE
    } wr_state_e;

endpackage

`default_nettype wire

// File: logic/line_read_engine.sv
`timescale 1ns/1ps
`default_nettype none

module line_read_engine
    import bus_pkg::*;
(
    input  logic       clk,
    input  logic       resetn,
    line_req_if.engine cache,
    axi_rd_if.master   bus
);

    rd_state_e         state_q;
    rd_state_e         state_d;
    logic [BEAT_W-1:0] beat_q;
    addr_t             addr_q;
    line_t             line_q;
    logic              take_req;
    logic              take_beat;

    assign take_req  = cache.req && cache.rdy;
    assign take_beat = bus.rvalid && bus.rready;

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            RD_IDLE: begin
                if (cache.req) begin
                    state_d = RD_ADDR;
                end
            end
            RD_ADDR: begin
                if (bus.arready) begin
                    state_d = RD_DATA;
                end
            end
            RD_DATA: begin
                // burst ends on rlast, not on the beat count
                if (take_beat && bus.rlast) begin
                    state_d = RD_DONE;
                end
            end
            RD_DONE: begin
                state_d = RD_IDLE;
            end
            default: begin
                state_d = RD_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state_q <= RD_IDLE;
            beat_q  <= '0;
        end else begin
            state_q <= state_d;
            if (take_req) begin
                beat_q <= '0;
            end else if (take_beat) begin
                beat_q <= beat_q + 1'b1;
            end
        end
    end

    // beat k lands in word k
    always_ff @(posedge clk) begin
        if (take_req) begin
            addr_q <= cache.addr;
            line_q <= '0;
        end else if (take_beat) begin
            line_q[beat_q*WORD_W +: WORD_W] <= bus.rdata;
        end
    end

    assign cache.rdy  = (state_q == RD_IDLE);
    assign cache.done = (state_q == RD_DONE);
    assign cache.data = line_q;

    assign bus.arvalid = (state_q == RD_ADDR);
    assign bus.araddr  = addr_q;
    assign bus.rready  = (state_q == RD_DATA) && bus.rvalid;

endmodule

`default_nettype wire

// File: logic/line_req_if.sv
`timescale 1ns/1ps
`default_nettype none

interface line_req_if
    import bus_pkg::*;
();

    logic  req;
    addr_t addr;
    logic  rdy;
    logic  done;
    // cache to engine on writes, engine to cache on reads
    line_t data;

    modport cache (
        output req,
        output addr,
        input  rdy,
        input  done,
        inout  data
    );

    modport engine (
        input  req,
        input  addr,
        output rdy,
        output done,
        inout  data
    );

endinterface

`default_nettype wire

// File: logic/line_write_engine.sv
`timescale 1ns/1ps
`default_nettype none

module line_write_engine
    import bus_pkg::*;
(
    input  logic       clk,
    input  logic       resetn,
    line_req_if.engine cache,
    output addr_t      m_awaddr,
    output logic       m_awvalid,
    input  logic       m_awready,
    output word_t      m_wdata,
    output logic       m_wlast,
    output logic       m_wvalid,
    input  logic       m_wready,
    input  logic       m_bvalid
);

    wr_state_e         state_q;
    wr_state_e         state_d;
    logic [BEAT_W-1:0] beat_q;
    addr_t             addr_q;
    line_t             line_q;
    logic              take_req;
    logic              take_beat;

    assign take_req  = cache.req && cache.rdy;
    assign take_beat = m_wvalid && m_wready;

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            WR_IDLE: begin
                if (cache.req) begin
                    state_d = WR_ADDR;
                end
            end
            WR_ADDR: begin
                if (m_awready) begin
                    state_d = WR_DATA;
                end
            end
            WR_DATA: begin
                if (take_beat && m_wlast) begin
                    state_d = WR_RESP;
                end
            end
            WR_RESP: begin
                if (m_bvalid) begin
                    state_d = WR_DONE;
                end
            end
            WR_DONE: begin
                state_d = WR_IDLE;
            end
            default: begin
                state_d = WR_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state_q <= WR_IDLE;
            beat_q  <= '0;
        end else begin
            state_q <= state_d;
            if (take_req) begin
                beat_q <= '0;
            end else if (take_beat) begin
                beat_q <= beat_q + 1'b1;
            end
        end
    end

    // line is held for the whole burst
    always_ff @(posedge clk) begin
        if (take_req) begin
            addr_q <= cache.addr;
            line_q <= cache.data;
        end
    end

    assign cache.rdy  = (state_q == WR_IDLE);
    assign cache.done = (state_q == WR_DONE);

    assign m_awvalid = (state_q == WR_ADDR);
    assign m_awaddr  = addr_q;

    assign m_wvalid = (state_q == WR_DATA);
    assign m_wdata  = line_q[beat_q*WORD_W +: WORD_W];
    assign m_wlast  = m_wvalid && (beat_q == BEAT_W'(LINE_WORDS - 1));

endmodule

`default_nettype wire

// File: logic/mem_bus_unit.sv
`timescale 1ns/1ps
`default_nettype none

module mem_bus_unit
    import bus_pkg::*;
(
    input  logic    clk,
    input  logic    resetn,

    input  logic    icache_rd_req,
    input  addr_t   icache_rd_addr,
    output logic    icache_rd_rdy,
    output logic    icache_ret_valid,
    output line_t   icache_ret_data,

    input  logic    dcache_rd_req,
    input  addr_t   dcache_rd_addr,
    output logic    dcache_rd_rdy,
    output logic    dcache_ret_valid,
    output line_t   dcache_ret_data,

    input  logic    dcache_wr_req,
    input  addr_t   dcache_wr_addr,
    input  line_t   dcache_wr_data,
    output logic    dcache_wr_rdy,
    output logic    dcache_wr_valid,

    output axi_id_t m_arid,
    output addr_t   m_araddr,
    output logic    m_arvalid,
    input  logic    m_arready,
    input  axi_id_t m_rid,
    input  word_t   m_rdata,
    input  logic    m_rlast,
    input  logic    m_rvalid,
    output logic    m_rready,

    output addr_t   m_awaddr,
    output logic    m_awvalid,
    input  logic    m_awready,
    output word_t   m_wdata,
    output logic    m_wlast,
    output logic    m_wvalid,
    input  logic    m_wready,
    input  logic    m_bvalid
);

    line_req_if ic_rd ();
    line_req_if dc_rd ();
    line_req_if dc_wr ();

    axi_rd_if ic_bus ();
    axi_rd_if dc_bus ();

    // cache side
    assign ic_rd.req        = icache_rd_req;
    assign ic_rd.addr       = icache_rd_addr;
    assign icache_rd_rdy    = ic_rd.rdy;
    assign icache_ret_valid = ic_rd.done;
    assign icache_ret_data  = ic_rd.data;

    assign dc_rd.req        = dcache_rd_req;
    assign dc_rd.addr       = dcache_rd_addr;
    assign dcache_rd_rdy    = dc_rd.rdy;
    assign dcache_ret_valid = dc_rd.done;
    assign dcache_ret_data  = dc_rd.data;

    assign dc_wr.req        = dcache_wr_req;
    assign dc_wr.addr       = dcache_wr_addr;
    assign dc_wr.data       = dcache_wr_data;
    assign dcache_wr_rdy    = dc_wr.rdy;
    assign dcache_wr_valid  = dc_wr.done;

    line_read_engine u_icache_rd (
        .clk    (clk),
        .resetn (resetn),
        .cache  (ic_rd),
        .bus    (ic_bus)
    );

    line_read_engine u_dcache_rd (
        .clk    (clk),
        .resetn (resetn),
        .cache  (dc_rd),
        .bus    (dc_bus)
    );

    // both readers share the one read channel
    read_arbiter u_rd_arb (
        .clk       (clk),
        .resetn    (resetn),
        .icache_rd (ic_bus),
        .dcache_rd (dc_bus),
        .m_arid    (m_arid),
        .m_araddr  (m_araddr),
        .m_arvalid (m_arvalid),
        .m_arready (m_arready),
        .m_rid     (m_rid),
        .m_rdata   (m_rdata),
        .m_rlast   (m_rlast),
        .m_rvalid  (m_rvalid),
        .m_rready  (m_rready)
    );

    line_write_engine u_dcache_wr (
        .clk       (clk),
        .resetn    (resetn),
        .cache     (dc_wr),
        .m_awaddr  (m_awaddr),
        .m_awvalid (m_awvalid),
        .m_awready (m_awready),
        .m_wdata   (m_wdata),
        .m_wlast   (m_wlast),
        .m_wvalid  (m_wvalid),
        .m_wready  (m_wready),
        .m_bvalid  (m_bvalid)
    );

endmodule

`default_nettype wire

// File: logic/read_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module read_arbiter
    import bus_pkg::*;
(
    input  logic    clk,
    input  logic    resetn,
    axi_rd_if.slave icache_rd,
    axi_rd_if.slave dcache_rd,
    output axi_id_t m_arid,
    output addr_t   m_araddr,
    output logic    m_arvalid,
    input  logic    m_arready,
    input  axi_id_t m_rid,
    input  word_t   m_rdata,
    input  logic    m_rlast,
    input  logic    m_rvalid,
    output logic    m_rready
);

    // 1 when the dcache reader held the address channel last
    logic last_dc_q;
    // a shown request is still waiting for arready
    logic hold_q;
    logic grant_dc;
    logic rid_ic;
    logic rid_dc;

    always_comb begin
        if (hold_q) begin
            grant_dc = last_dc_q;
        end else if (icache_rd.arvalid && dcache_rd.arvalid) begin
            grant_dc = !last_dc_q;
        end else begin
            grant_dc = dcache_rd.arvalid;
        end
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            last_dc_q <= 1'b0;
            hold_q    <= 1'b0;
        end else begin
            hold_q <= m_arvalid && !m_arready;
            if (m_arvalid) begin
                last_dc_q <= grant_dc;
            end
        end
    end

    assign m_arvalid = grant_dc ? dcache_rd.arvalid : icache_rd.arvalid;
    assign m_araddr  = grant_dc ? dcache_rd.araddr : icache_rd.araddr;
    assign m_arid    = grant_dc ? DCACHE_ID : ICACHE_ID;

    assign icache_rd.arready = m_arready && !grant_dc;
    assign dcache_rd.arready = m_arready && grant_dc;

    // steer returning beats by ID
    assign rid_ic = (m_rid == ICACHE_ID);
    assign rid_dc = (m_rid == DCACHE_ID);

    assign icache_rd.rvalid = m_rvalid && rid_ic;
    assign icache_rd.rdata  = m_rdata;
    assign icache_rd.rlast  = m_rlast;

    assign dcache_rd.rvalid = m_rvalid && rid_dc;
    assign dcache_rd.rdata  = m_rdata;
    assign dcache_rd.rlast  = m_rlast;

    assign m_rready = (rid_ic && icache_rd.rready) || (rid_dc && dcache_rd.rready);

endmodule

`default_nettype wire

// File: verif/axi_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module axi_mem_model
    import bus_pkg::*;
(
    input  logic       clk,
    input  logic       resetn,
    // per-cycle enables for arready, rvalid, awready, wready, bvalid
    input  logic [4:0] go,
    // which pending read burst to serve when both have one
    input  logic       pick,
    input  axi_id_t    arid,
    input  addr_t      araddr,
    input  logic       arvalid,
    output logic       arready,
    output axi_id_t    rid,
    output word_t      rdata,
    output logic       rlast,
    output logic       rvalid,
    input  logic       rready,
    input  addr_t      awaddr,
    input  logic       awvalid,
    output logic       awready,
    input  word_t      wdata,
    input  logic       wlast,
    input  logic       wvalid,
    output logic       wready,
    output logic       bvalid
);

    word_t      mem [64];
    logic [1:0] pend_q;
    logic [3:0] rline_q [2];
    logic [1:0] rbeat_q [2];
    axi_id_t    rid_q [2];
    logic       sel;
    logic       aw_got_q;
    logic       b_pend_q;
    logic [5:0] wptr_q;

    // same fill as the reference copy in the testbench
    initial begin
        for (int i = 0; i < 64; i++) begin
            mem[i] = 32'h3c00_0000 ^ (word_t'(i) * 32'h0101_0107);
        end
    end

    assign sel     = (pend_q == 2'b11) ? pick : pend_q[1];
    assign arready = go[4] && !pend_q[arid[0]];
    assign rvalid  = go[3] && pend_q[sel];
    assign rid     = rid_q[sel];
    assign rdata   = mem[{rline_q[sel], rbeat_q[sel]}];
    assign rlast   = (rbeat_q[sel] == 2'd3);
    assign awready = go[2] && !aw_got_q;
    assign wready  = go[1] && aw_got_q && !b_pend_q;
    assign bvalid  = go[0] && b_pend_q;

    always @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            pend_q   <= '0;
            aw_got_q <= 1'b0;
            b_pend_q <= 1'b0;
            wptr_q   <= '0;
            for (int s = 0; s < 2; s++) begin
                rline_q[s] <= '0;
                rbeat_q[s] <= '0;
                rid_q[s]   <= '0;
            end
        end else begin
            // one pending burst per ID
            if (arvalid && arready) begin
                pend_q[arid[0]]  <= 1'b1;
                rline_q[arid[0]] <= araddr[7:4];
                rbeat_q[arid[0]] <= '0;
                rid_q[arid[0]]   <= arid;
            end
            if (rvalid && rready) begin
                rbeat_q[sel] <= rbeat_q[sel] + 2'd1;
                if (rlast) begin
                    pend_q[sel] <= 1'b0;
                end
            end
            if (awvalid && awready) begin
                aw_got_q <= 1'b1;
                wptr_q   <= awaddr[7:2];
            end
            if (wvalid && wready) begin
                wptr_q <= wptr_q + 6'd1;
                if (wlast) begin
                    b_pend_q <= 1'b1;
                end
            end
            if (bvalid) begin
                b_pend_q <= 1'b0;
                aw_got_q <= 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        if (wvalid && wready) begin
            mem[wptr_q] <= wdata;
        end
    end

endmodule

`default_nettype wire

// File: verif/tb_mem_bus_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_bus_unit
    import bus_pkg::*;
();

    localparam int          CLK_HALF     = 2;
    localparam int          N_PER        = 20;
    localparam int          WORST_CYCLES = 300;
    localparam int          WATCHDOG_NS  = (3 * N_PER * WORST_CYCLES + 8) * 2 * CLK_HALF;
    localparam logic [31:0] SEED         = 32'heb0ccc5b;

    logic clk;
    logic resetn;
    logic icache_rd_req, icache_rd_rdy, icache_ret_valid;
    addr_t icache_rd_addr;
    line_t icache_ret_data;
    logic dcache_rd_req, dcache_rd_rdy, dcache_ret_valid;
    addr_t dcache_rd_addr;
    line_t dcache_ret_data;
    logic dcache_wr_req, dcache_wr_rdy, dcache_wr_valid;
    addr_t dcache_wr_addr;
    line_t dcache_wr_data;
    axi_id_t m_arid, m_rid;
    addr_t m_araddr, m_awaddr;
    word_t m_rdata, m_wdata;
    logic m_arvalid, m_arready, m_rlast, m_rvalid, m_rready;
    logic m_awvalid, m_awready, m_wlast, m_wvalid, m_wready, m_bvalid;
    logic [4:0] go;
    logic pick;

    logic [2:0] rdy_v;
    logic [2:0] done_v;
    logic [2:0] req_v;

    // channel 0 icache read, 1 dcache read, 2 dcache write
    logic        busy [3];
    logic        taken [3];
    logic [3:0]  line_no [3];
    int          issued [3];
    word_t       ref_mem [64];
    line_t       wr_line;
    logic [3:0]  last_wr_line;
    int          aw_cnt, w_cnt, done_cnt, checks, errors;
    logic        b_seen;
    logic [31:0] lfsr_q;

    assign rdy_v  = {dcache_wr_rdy, dcache_rd_rdy, icache_rd_rdy};
    assign done_v = {dcache_wr_valid, dcache_ret_valid, icache_ret_valid};
    assign req_v  = {dcache_wr_req, dcache_rd_req, icache_rd_req};

    mem_bus_unit i_dut (.*);

    axi_mem_model u_mem (
        .clk(clk), .resetn(resetn), .go(go), .pick(pick),
        .arid(m_arid), .araddr(m_araddr), .arvalid(m_arvalid), .arready(m_arready),
        .rid(m_rid), .rdata(m_rdata), .rlast(m_rlast), .rvalid(m_rvalid), .rready(m_rready),
        .awaddr(m_awaddr), .awvalid(m_awvalid), .awready(m_awready),
        .wdata(m_wdata), .wlast(m_wlast), .wvalid(m_wvalid), .wready(m_wready),
        .bvalid(m_bvalid)
    );

    always #(CLK_HALF) clk = ~clk;

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic word_t take_bits(input int n);
        word_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    function automatic addr_t line_addr(input logic [3:0] line);
        return {24'd0, line, 4'd0};
    endfunction

    function automatic line_t expect_line(input logic [3:0] line);
        int b;
        b = int'(line) * 4;
        return {ref_mem[b + 3], ref_mem[b + 2], ref_mem[b + 1], ref_mem[b]};
    endfunction

    task automatic check_line(input string name, input line_t got, input line_t exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_true(input logic ok, input string what);
        checks++;
        assert (ok) else begin
            errors++;
            $display("error at %0t ns: %s", $time, what);
        end
    endtask

    // pick a line, keeping reads and writes of one line apart
    task automatic choose_line(input int c, output logic [3:0] line);
        word_t r;
        r = take_bits(5);
        line = r[3:0];
        if (c < 2 && r[4]) begin
            line = last_wr_line;
        end
        while ((c == 2 && ((busy[0] && line == line_no[0]) || (busy[1] && line == line_no[1])))
               || (c < 2 && busy[2] && line == line_no[2])) begin
            line = line + 4'd1;
        end
    endtask

    task automatic start_request(input int c, input logic [3:0] line);
        case (c)
            0: begin
                icache_rd_req  <= 1'b1;
                icache_rd_addr <= line_addr(line);
            end
            1: begin
                dcache_rd_req  <= 1'b1;
                dcache_rd_addr <= line_addr(line);
            end
            default: begin
                for (int k = 0; k < 4; k++) begin
                    wr_line[k * WORD_W +: WORD_W] = take_bits(32);
                end
                dcache_wr_req  <= 1'b1;
                dcache_wr_addr <= line_addr(line);
                dcache_wr_data <= wr_line;
            end
        endcase
        line_no[c] = line;
        busy[c] = 1'b1;
        issued[c]++;
    endtask

    task automatic drive_cycle();
        word_t r;
        logic [3:0] line;
        r = take_bits(6);
        go   <= r[5:1];
        pick <= r[0];
        for (int c = 0; c < 3; c++) begin
            if (taken[c]) begin
                if (c == 0) icache_rd_req <= 1'b0;
                if (c == 1) dcache_rd_req <= 1'b0;
                if (c == 2) dcache_wr_req <= 1'b0;
            end else if (!busy[c] && issued[c] < N_PER) begin
                r = take_bits(2);
                if (r[1:0] == 2'b00) begin
                    choose_line(c, line);
                    start_request(c, line);
                end
            end
        end
    endtask

    // memory port traffic seen this cycle
    task automatic watch_bus();
        if (m_arvalid && m_arready) begin
            if (m_arid == ICACHE_ID) begin
                check_word("m_araddr", m_araddr, line_addr(line_no[0]));
            end else if (m_arid == DCACHE_ID) begin
                check_word("m_araddr", m_araddr, line_addr(line_no[1]));
            end else begin
                check_true(1'b0, "address phase with an unknown read ID");
            end
        end
        if (m_awvalid && m_awready) begin
            check_true(aw_cnt == 0, "second address phase in one line write");
            check_word("m_awaddr", m_awaddr, line_addr(line_no[2]));
            aw_cnt++;
        end
        if (m_wvalid && m_wready) begin
            check_true(aw_cnt == 1 && w_cnt < 4, "write beat outside a line write");
            check_word("m_wdata", m_wdata, wr_line[(w_cnt % 4) * WORD_W +: WORD_W]);
            check_word("m_wlast", word_t'(m_wlast), word_t'(w_cnt == 3));
            w_cnt++;
        end
        if (m_bvalid) begin
            b_seen = 1'b1;
        end
    endtask

    task automatic finish_request(input int c);
        case (c)
            0: check_line("icache_ret_data", icache_ret_data, expect_line(line_no[0]));
            1: check_line("dcache_ret_data", dcache_ret_data, expect_line(line_no[1]));
            default: begin
                check_true(aw_cnt == 1 && w_cnt == 4, "line write ended without a full burst");
                check_true(b_seen, "dcache_wr_valid came before the write response");
                for (int k = 0; k < 4; k++) begin
                    ref_mem[int'(line_no[2]) * 4 + k] = wr_line[k * WORD_W +: WORD_W];
                end
                last_wr_line = line_no[2];
                aw_cnt = 0;
                w_cnt = 0;
                b_seen = 1'b0;
            end
        endcase
        busy[c] = 1'b0;
        taken[c] = 1'b0;
        done_cnt++;
    endtask

    initial begin : stimulus
        clk = 1'b0;
        resetn = 1'b0;
        icache_rd_req = 1'b0;
        icache_rd_addr = '0;
        dcache_rd_req = 1'b0;
        dcache_rd_addr = '0;
        dcache_wr_req = 1'b0;
        dcache_wr_addr = '0;
        dcache_wr_data = '0;
        go = '0;
        pick = 1'b0;
        lfsr_q = SEED;
        wr_line = '0;
        last_wr_line = '0;
        aw_cnt = 0;
        w_cnt = 0;
        done_cnt = 0;
        checks = 0;
        errors = 0;
        b_seen = 1'b0;
        for (int c = 0; c < 3; c++) begin
            busy[c] = 1'b0;
            taken[c] = 1'b0;
            line_no[c] = '0;
            issued[c] = 0;
        end
        for (int i = 0; i < 64; i++) begin
            ref_mem[i] = 32'h3c00_0000 ^ (word_t'(i) * 32'h0101_0107);
        end

        repeat (8) @(posedge clk);
        resetn <= 1'b1;
        @(negedge clk);
        check_true(icache_rd_rdy && dcache_rd_rdy && dcache_wr_rdy, "rdy low after reset");
        check_true(!(icache_ret_valid || dcache_ret_valid || dcache_wr_valid),
                   "done high after reset");
        check_true(!(m_arvalid || m_awvalid || m_wvalid || m_wlast || m_rready),
                   "memory port active after reset");

        while (done_cnt < 3 * N_PER) begin
            @(posedge clk);
            drive_cycle();
            @(negedge clk);
            watch_bus();
            for (int c = 0; c < 3; c++) begin
                if (done_v[c]) begin
                    check_true(taken[c], "done pulse with no request in flight");
                    finish_request(c);
                end else if (taken[c]) begin
                    check_true(!rdy_v[c], "rdy high while a request is in flight");
                end else if (req_v[c] && rdy_v[c]) begin
                    taken[c] = 1'b1;
                end
            end
        end

        $display("requests %0d, checks %0d, errors %0d", done_cnt, checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("error: run did not finish within %0d ns, requests done %0d",
                 WATCHDOG_NS, done_cnt);
        $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire
